// File: hw/rv_isa_pkg.sv
// RV32I instruction encodings used by the core

package rv_isa_pkg;

  // ------------------------------
  // Major opcodes
  // ------------------------------
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_RTYPE  = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // ------------------------------
  // funct3 codes
  // ------------------------------
  // Conditional branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Word access, the only load/store width kept
  localparam logic [2:0] F3_W = 3'b010;

  // Integer arithmetic, shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;

  // funct7 values: base form and SUB/SRA form
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // Full EBREAK encoding
  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

  // Same 32-bit word seen through each encoding format
  // B and J immediates are taken from the s and u views
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic [19:0] imm20;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
  } instr_t;

endpackage

// File: hw/rv_core_pkg.sv
// Core-level widths and internal control encodings

package rv_core_pkg;

  // Datapath and register index widths
  localparam int XLEN   = 32;
  localparam int REG_AW = 5;

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [REG_AW-1:0] reg_idx_t;

  // First fetch address out of reset
  localparam logic [31:0] RESET_PC = 32'h0000_0000;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_t;

  // Write-back source
  typedef enum logic [1:0] {
    RES_ALU,
    RES_MEM,
    RES_PC4
  } res_src_t;

  // ALU operand A source
  typedef enum logic {
    A_RS1,
    A_PC
  } alu_a_t;

endpackage

// File: hw/rv_ctrl_if.sv
`timescale 1ns/1ps

// Decoded control for one instruction, decode to execute and result
interface rv_ctrl_if import rv_core_pkg::*; ();

  alu_op_t  alu_op;
  alu_a_t   a_src;
  logic     b_is_imm;
  word_t    imm;
  res_src_t res_src;
  logic     reg_write;
  logic     mem_read;
  logic     mem_write;
  logic     is_branch;
  logic     is_jal;
  logic     is_jalr;
  logic [2:0] funct3;
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  logic     illegal;
  logic     is_ebreak;

  // Decoder side
  modport dec (
    output alu_op, a_src, b_is_imm, imm, res_src, reg_write, mem_read, mem_write,
    output is_branch, is_jal, is_jalr, funct3, rs1, rs2, rd, illegal, is_ebreak
  );

  // ALU, branch and PC side
  modport exe (
    input alu_op, a_src, b_is_imm, imm, mem_read, mem_write,
    input is_branch, is_jal, is_jalr, funct3, illegal
  );

  // Register file and halt side
  modport res (
    input rs1, rs2, rd, reg_write, res_src, illegal, is_ebreak
  );

endinterface

// File: hw/rv_decode.sv
`timescale 1ns/1ps

// Combinational RV32I decoder for the kept instruction subset
module rv_decode import rv_isa_pkg::*, rv_core_pkg::*; (
  input instr_t  instr,
  rv_ctrl_if.dec ctrl
);

  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  logic [6:0] funct7;
  logic [2:0] funct3;
  logic       is_rtype;
  logic       is_shift;
  logic       f7_ok;
  alu_op_t    arith_op;

  // ------------------------------
  // Fields and immediates
  // ------------------------------
  assign funct7   = instr.r.funct7;
  assign funct3   = instr.r.funct3;
  assign is_rtype = (instr.r.opcode == OP_RTYPE);
  assign is_shift = (funct3 == F3_SLL) || (funct3 == F3_SR);

  assign imm_i = {{20{instr.i.imm12[11]}}, instr.i.imm12};
  assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
  // B: bit 11 sits in imm_lo[0], bit 12 in the sign position
  assign imm_b = {{20{instr.s.imm_hi[6]}}, instr.s.imm_lo[0], instr.s.imm_hi[5:0],
                  instr.s.imm_lo[4:1], 1'b0};
  assign imm_u = {instr.u.imm20, 12'b0};
  // J: scrambled imm20 field, bit 0 always zero
  assign imm_j = {{12{instr.u.imm20[19]}}, instr.u.imm20[7:0], instr.u.imm20[8],
                  instr.u.imm20[18:9], 1'b0};

  // Register fields pass straight through
  assign ctrl.funct3 = funct3;
  assign ctrl.rs1    = instr.r.rs1;
  assign ctrl.rs2    = instr.r.rs2;
  assign ctrl.rd     = instr.r.rd;

  // funct7 must be zero, except SUB and the arithmetic right shifts
  assign f7_ok = (funct7 == F7_BASE) ||
                 ((funct7 == F7_ALT) && ((funct3 == F3_SR) || (is_rtype && (funct3 == F3_ADD))));

  // ALU op for OP and OP-IMM
  always_comb begin
    case (funct3)
      F3_ADD:  arith_op = (is_rtype && funct7[5]) ? ALU_SUB : ALU_ADD;
      F3_SLL:  arith_op = ALU_SLL;
      F3_SLT:  arith_op = ALU_SLT;
      F3_SLTU: arith_op = ALU_SLTU;
      F3_XOR:  arith_op = ALU_XOR;
      F3_SR:   arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
      F3_OR:   arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  // ------------------------------
  // Opcode decode
  // ------------------------------
  always_comb begin
    // Defaults describe a no-op that writes nothing
    ctrl.alu_op    = ALU_ADD;
    ctrl.a_src     = A_RS1;
    ctrl.b_is_imm  = 1'b0;
    ctrl.imm       = imm_i;
    ctrl.res_src   = RES_ALU;
    ctrl.reg_write = 1'b0;
    ctrl.mem_read  = 1'b0;
    ctrl.mem_write = 1'b0;
    ctrl.is_branch = 1'b0;
    ctrl.is_jal    = 1'b0;
    ctrl.is_jalr   = 1'b0;
    ctrl.illegal   = 1'b0;
    ctrl.is_ebreak = 1'b0;
    case (instr.r.opcode)
      OP_LUI: begin
        ctrl.alu_op    = ALU_PASS_B;
        ctrl.b_is_imm  = 1'b1;
        ctrl.imm       = imm_u;
        ctrl.reg_write = 1'b1;
      end
      OP_AUIPC: begin
        ctrl.a_src     = A_PC;
        ctrl.b_is_imm  = 1'b1;
        ctrl.imm       = imm_u;
        ctrl.reg_write = 1'b1;
      end
      OP_JAL: begin
        ctrl.is_jal    = 1'b1;
        ctrl.imm       = imm_j;
        ctrl.res_src   = RES_PC4;
        ctrl.reg_write = 1'b1;
      end
      OP_JALR: begin
        // Target comes from the ALU sum rs1 + imm
        ctrl.is_jalr   = 1'b1;
        ctrl.b_is_imm  = 1'b1;
        ctrl.res_src   = RES_PC4;
        ctrl.reg_write = 1'b1;
        ctrl.illegal   = (funct3 != 3'b000);
      end
      OP_BRANCH: begin
        ctrl.is_branch = 1'b1;
        ctrl.imm       = imm_b;
        ctrl.illegal   = !(funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU});
      end
      OP_LOAD: begin
        ctrl.b_is_imm  = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.res_src   = RES_MEM;
        ctrl.reg_write = 1'b1;
        ctrl.illegal   = (funct3 != F3_W);
      end
      OP_STORE: begin
        ctrl.b_is_imm  = 1'b1;
        ctrl.imm       = imm_s;
        ctrl.mem_write = 1'b1;
        ctrl.illegal   = (funct3 != F3_W);
      end
      OP_IMM: begin
        // Only shifts carry a funct7 field in the immediate
        ctrl.alu_op    = arith_op;
        ctrl.b_is_imm  = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.illegal   = is_shift && !f7_ok;
      end
      OP_RTYPE: begin
        ctrl.alu_op    = arith_op;
        ctrl.reg_write = 1'b1;
        ctrl.illegal   = !f7_ok;
      end
      OP_SYSTEM: begin
        // EBREAK is the only SYSTEM word accepted
        ctrl.is_ebreak = (instr == EBREAK_WORD);
        ctrl.illegal   = (instr != EBREAK_WORD);
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

endmodule

// File: hw/rv_execute.sv
`timescale 1ns/1ps

// ALU, branch compare, data memory address and program counter
module rv_execute import rv_isa_pkg::*, rv_core_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  rv_ctrl_if.exe ctrl,
  input  word_t  rs1_data,
  input  word_t  rs2_data,
  input  logic   halted,
  output word_t  pc,
  output word_t  alu_result,
  output word_t  pc_plus4,
  output logic   misaligned,
  output word_t  dmem_addr,
  output word_t  dmem_wdata,
  output logic   dmem_re,
  output logic   dmem_we
);

  word_t      alu_a;
  word_t      alu_b;
  logic [4:0] shamt;
  logic       br_eq;
  logic       br_lt;
  logic       br_ltu;
  logic       br_taken;
  word_t      br_target;
  word_t      jalr_target;
  logic       redirect;
  word_t      next_pc;
  logic       mem_ok;

  // ------------------------------
  // ALU
  // ------------------------------
  assign alu_a = (ctrl.a_src == A_PC) ? pc : rs1_data;
  assign alu_b = ctrl.b_is_imm ? ctrl.imm : rs2_data;
  assign shamt = alu_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:  alu_result = alu_a + alu_b;
      ALU_SUB:  alu_result = alu_a - alu_b;
      ALU_SLL:  alu_result = alu_a << shamt;
      ALU_SLT:  alu_result = ($signed(alu_a) < $signed(alu_b)) ? 32'd1 : 32'd0;
      ALU_SLTU: alu_result = (alu_a < alu_b) ? 32'd1 : 32'd0;
      ALU_XOR:  alu_result = alu_a ^ alu_b;
      ALU_SRL:  alu_result = alu_a >> shamt;
      ALU_SRA:  alu_result = $signed(alu_a) >>> shamt;
      ALU_OR:   alu_result = alu_a | alu_b;
      ALU_AND:  alu_result = alu_a & alu_b;
      default:  alu_result = alu_b;
    endcase
  end

  // ------------------------------
  // Branch compare
  // ------------------------------
  // Always on the register operands, independent of the ALU B mux
  assign br_eq  = (rs1_data == rs2_data);
  assign br_lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign br_ltu = (rs1_data < rs2_data);

  always_comb begin
    case (ctrl.funct3)
      F3_BEQ:  br_taken = br_eq;
      F3_BNE:  br_taken = !br_eq;
      F3_BLT:  br_taken = br_lt;
      F3_BGE:  br_taken = !br_lt;
      F3_BLTU: br_taken = br_ltu;
      F3_BGEU: br_taken = !br_ltu;
      default: br_taken = 1'b0;
    endcase
  end

  // ------------------------------
  // Next PC
  // ------------------------------
  assign pc_plus4  = pc + 32'd4;
  // JAL and branches are PC-relative
  assign br_target = pc + ctrl.imm;
  // JALR: rs1 + imm from the ALU, bit 0 dropped
  assign jalr_target = {alu_result[31:1], 1'b0};

  assign redirect = ctrl.is_jal || (ctrl.is_branch && br_taken);

  always_comb begin
    if (ctrl.is_jalr) begin
      next_pc = jalr_target;
    end else if (redirect) begin
      next_pc = br_target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  // Targets and word addresses must be 4-byte aligned
  assign misaligned = (ctrl.is_jalr && jalr_target[1]) ||
                      (redirect && (br_target[1:0] != 2'b00)) ||
                      ((ctrl.mem_read || ctrl.mem_write) && (alu_result[1:0] != 2'b00));

  // PC freezes once the core has halted
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (!halted) begin
      pc <= next_pc;
    end
  end

  // ------------------------------
  // Data memory
  // ------------------------------
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rs2_data;

  // No access from a halted core or a trapping instruction
  assign mem_ok  = !halted && !ctrl.illegal && !misaligned;
  assign dmem_re = ctrl.mem_read && mem_ok;
  assign dmem_we = ctrl.mem_write && mem_ok;

endmodule

// File: hw/rv_result.sv
`timescale 1ns/1ps

// Register file, write-back select and sticky halt flags
module rv_result import rv_core_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  rv_ctrl_if.res ctrl,
  input  word_t  alu_result,
  input  word_t  pc_plus4,
  input  word_t  dmem_rdata,
  input  logic   misaligned,
  output word_t  rs1_data,
  output word_t  rs2_data,
  output logic   halted,
  output logic   ebreak,
  output logic   trap
);

  // x1..x31, x0 is hardwired
  word_t regs [1:31];
  word_t wb_data;
  logic  trapping;
  logic  commit;

  // ------------------------------
  // Register read
  // ------------------------------
  // Combinational, same cycle as decode
  assign rs1_data = (ctrl.rs1 == '0) ? '0 : regs[ctrl.rs1];
  assign rs2_data = (ctrl.rs2 == '0) ? '0 : regs[ctrl.rs2];

  // ------------------------------
  // Write-back
  // ------------------------------
  always_comb begin
    case (ctrl.res_src)
      RES_MEM: wb_data = dmem_rdata;
      RES_PC4: wb_data = pc_plus4;
      default: wb_data = alu_result;
    endcase
  end

  assign trapping = ctrl.illegal || misaligned;

  // Trapping instructions and EBREAK retire without a write
  assign commit = ctrl.reg_write && !trapping && !ctrl.is_ebreak && !halted &&
                  (ctrl.rd != '0);

  always_ff @(posedge clk) begin
    if (commit) begin
      regs[ctrl.rd] <= wb_data;
    end
  end

  // ------------------------------
  // Halt flags
  // ------------------------------
  // Both flags stick until reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ebreak <= 1'b0;
      trap   <= 1'b0;
    end else begin
      ebreak <= ebreak || (!halted && ctrl.is_ebreak);
      trap   <= trap || (!halted && trapping);
    end
  end

  assign halted = ebreak || trap;

endmodule

// File: hw/rv_core.sv
`timescale 1ns/1ps

// Single-cycle RV32I core, one instruction retired per clock
module rv_core import rv_core_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  // Instruction memory, zero latency
  output logic        imem_ren,
  output logic [31:0] imem_raddr,
  input  logic [31:0] imem_rdata,

  // Data memory read, answered in the same cycle
  output logic        dmem_ren,
  output logic [31:0] dmem_raddr,
  input  logic [31:0] dmem_rdata,

  // Data memory write, full word only
  output logic        dmem_we,
  output logic [31:0] dmem_waddr,
  output logic [31:0] dmem_wdata,

  output logic        ebreak,
  output logic        trap
);

  word_t rs1_data;
  word_t rs2_data;
  word_t alu_result;
  word_t pc_plus4;
  word_t dmem_addr;
  logic  misaligned;
  logic  halted;

  rv_ctrl_if ctrl_if ();

  rv_decode decode_inst (
    .instr (imem_rdata),
    .ctrl  (ctrl_if.dec)
  );

  rv_execute execute_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl_if.exe),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .halted     (halted),
    .pc         (imem_raddr),
    .alu_result (alu_result),
    .pc_plus4   (pc_plus4),
    .misaligned (misaligned),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_re    (dmem_ren),
    .dmem_we    (dmem_we)
  );

  rv_result result_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl_if.res),
    .alu_result (alu_result),
    .pc_plus4   (pc_plus4),
    .dmem_rdata (dmem_rdata),
    .misaligned (misaligned),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .halted     (halted),
    .ebreak     (ebreak),
    .trap       (trap)
  );

  // One address feeds both data memory ports
  assign dmem_raddr = dmem_addr;
  assign dmem_waddr = dmem_addr;

  // Fetch stops once halted
  assign imem_ren = !halted;

endmodule

// File: verif/rv_core_props.sv
`timescale 1ns/1ps

// Halt and store invariants on the core top level
module rv_core_props (
  input logic        clk,
  input logic        rst_n,
  input logic        ebreak,
  input logic        trap,
  input logic        dmem_we,
  input logic [31:0] dmem_waddr
);

  // Flags are sticky until a reset
  ebreak_sticky: assert property (@(posedge clk) (ebreak && rst_n) |=> ebreak)
    else $error("ebreak fell without reset");

  trap_sticky: assert property (@(posedge clk) (trap && rst_n) |=> trap)
    else $error("trap fell without reset");

  // A halted core stores nothing
  no_store_halted: assert property (@(posedge clk) disable iff (!rst_n)
    (ebreak || trap) |-> !dmem_we)
    else $error("store while halted");

  store_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_we |-> (dmem_waddr[1:0] == 2'b00))
    else $error("misaligned store address");

endmodule

bind rv_core rv_core_props props_inst (.*);

// File: verif/rv_core_tb.sv
`timescale 1ns/1ps

// Random RV32I programs against a reference instruction model
module rv_core_tb import rv_isa_pkg::*, rv_core_pkg::*; ();

  localparam int NUM_PROGS = 8;
  localparam int LIMIT     = NUM_PROGS * (64 + 10);

  logic        clk;
  logic        rst_n;
  logic        imem_ren;
  logic [31:0] imem_raddr;
  logic [31:0] imem_rdata;
  logic        dmem_ren;
  logic [31:0] dmem_raddr;
  logic [31:0] dmem_rdata;
  logic        dmem_we;
  logic [31:0] dmem_waddr;
  logic [31:0] dmem_wdata;
  logic        ebreak;
  logic        trap;

  logic [31:0] imem [64];
  logic [31:0] dmem [32];
  int          cycles;

  // Expected results from the model
  logic [31:0] pc_q [$];
  logic        ld_en_q [$];
  logic [31:0] ld_addr_q [$];
  logic [31:0] st_addr_q [$];
  logic [31:0] st_data_q [$];
  logic        exp_ebreak;
  logic        exp_trap;

  rv_core rv_core_inst (.*);

  always #20 clk = ~clk;

  // Zero-latency memories, word indexed
  assign imem_rdata = imem[imem_raddr[7:2]];
  assign dmem_rdata = dmem[dmem_raddr[6:2]];

  always @(posedge clk) begin
    if (rst_n && dmem_we) begin
      dmem[dmem_waddr[6:2]] <= dmem_wdata;
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: core never halted");
      $display("Test FAILED");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      $display("Test FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // Data memory start pattern, depends on the whole word index
  function automatic logic [31:0] fill_word(input int i);
    return 32'(i + 1) * 32'h9E37_79B1 ^ {i[7:0], 24'h5A_C3_0F};
  endfunction

  // ------------------------------
  // Instruction encoders
  // ------------------------------
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    instr_t w;
    w.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: OP_RTYPE};
    return w;
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [11:0] imm,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    instr_t w;
    w.i = '{imm12: imm, rs1: rs1, funct3: f3, rd: rd, opcode: op};
    return w;
  endfunction

  // Store and branch share the S layout
  function automatic logic [31:0] enc_s(input logic [6:0] op, input logic [12:0] imm,
                                        input logic [4:0] rs2, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic is_b);
    instr_t w;
    if (is_b) begin
      w.s = '{imm_hi: {imm[12], imm[10:5]}, rs2: rs2, rs1: rs1, funct3: f3,
              imm_lo: {imm[4:1], imm[11]}, opcode: op};
    end else begin
      w.s = '{imm_hi: imm[11:5], rs2: rs2, rs1: rs1, funct3: f3,
              imm_lo: imm[4:0], opcode: op};
    end
    return w;
  endfunction

  function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [20:0] imm,
                                        input logic [4:0] rd);
    instr_t w;
    if (op == OP_JAL) begin
      w.u = '{imm20: {imm[20], imm[10:1], imm[11], imm[19:12]}, rd: rd, opcode: op};
    end else begin
      w.u = '{imm20: imm[19:0], rd: rd, opcode: op};
    end
    return w;
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic run_model();
    logic [31:0] x [32];
    logic [31:0] dm [32];
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] npc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] res;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        wr;
    logic        bad;
    logic        tk;
    logic        ld;
    pc_q.delete();
    ld_en_q.delete();
    ld_addr_q.delete();
    st_addr_q.delete();
    st_data_q.delete();
    exp_ebreak = 1'b0;
    exp_trap = 1'b0;
    x = '{default: '0};
    foreach (dm[j]) begin
      dm[j] = fill_word(j);
    end
    pc = RESET_PC;
    for (int s = 0; s < 100 && !exp_ebreak && !exp_trap; s++) begin
      w = imem[pc[7:2]];
      pc_q.push_back(pc);
      f3 = w[14:12];
      f7 = w[31:25];
      a = x[w[19:15]];
      b = x[w[24:20]];
      npc = pc + 4;
      wr = 1'b0;
      bad = 1'b0;
      res = '0;
      ld = 1'b0;
      addr = '0;
      case (w[6:0])
        OP_LUI: begin
          res = {w[31:12], 12'b0};
          wr = 1'b1;
        end
        OP_AUIPC: begin
          res = pc + {w[31:12], 12'b0};
          wr = 1'b1;
        end
        OP_JAL: begin
          npc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
          res = pc + 4;
          wr = 1'b1;
          bad = (npc[1:0] != 0);
        end
        OP_JALR: begin
          npc = (a + {{20{w[31]}}, w[31:20]}) & ~32'd1;
          res = pc + 4;
          wr = 1'b1;
          bad = (f3 != 0) || npc[1];
        end
        OP_BRANCH: begin
          case (f3)
            3'd0: tk = (a == b);
            3'd1: tk = (a != b);
            3'd4: tk = ($signed(a) < $signed(b));
            3'd5: tk = ($signed(a) >= $signed(b));
            3'd6: tk = (a < b);
            default: tk = (a >= b);
          endcase
          bad = (f3 == 3'd2) || (f3 == 3'd3);
          if (tk) begin
            npc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            bad = bad || (npc[1:0] != 0);
          end
        end
        OP_LOAD: begin
          addr = a + {{20{w[31]}}, w[31:20]};
          bad = (f3 != F3_W) || (addr[1:0] != 0);
          ld = !bad;
          res = dm[addr[6:2]];
          wr = 1'b1;
        end
        OP_STORE: begin
          addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
          bad = (f3 != F3_W) || (addr[1:0] != 0);
          if (!bad) begin
            dm[addr[6:2]] = b;
            st_addr_q.push_back(addr);
            st_data_q.push_back(b);
          end
        end
        OP_IMM: begin
          // Shift amounts carry funct7 in the upper immediate bits
          bad = (f3 == 3'd1 && f7 != 0) || (f3 == 3'd5 && f7 != 0 && f7 != 7'h20);
          res = ref_alu(f3, (f3 == 3'd5) && f7[5], a, {{20{w[31]}}, w[31:20]});
          wr = 1'b1;
        end
        OP_RTYPE: begin
          bad = !(f7 == 0 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
          res = ref_alu(f3, f7[5], a, b);
          wr = 1'b1;
        end
        OP_SYSTEM: begin
          exp_ebreak = (w == EBREAK_WORD);
          bad = (w != EBREAK_WORD);
        end
        default: bad = 1'b1;
      endcase
      ld_en_q.push_back(ld);
      ld_addr_q.push_back(addr);
      exp_trap = bad;
      if (!bad && !exp_ebreak) begin
        if (wr && w[11:7] != 0) begin
          x[w[11:7]] = res;
        end
        pc = npc;
      end
    end
  endtask

  // ------------------------------
  // Program generation
  // ------------------------------
  task automatic build_program();
    int n;
    int jp;
    int k;
    int tgt;
    logic [2:0] f3;
    logic [2:0] br_f3 [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    for (int i = 0; i < 64; i++) begin
      imem[i] = EBREAK_WORD;
    end
    n = 20 + $urandom % 16;
    // Seed x1..x7 so no register is read before it is written
    for (int i = 0; i < 7; i++) begin
      imem[i] = enc_i(OP_IMM, 12'($urandom), 5'd0, F3_ADD, 5'(i + 1));
    end
    jp = 7 + $urandom % (n - 9);
    for (int i = 7; i < n; i++) begin
      f3 = 3'($urandom);
      k = $urandom % 32;
      tgt = i + 1 + $urandom % (n - i);
      // Never land between the JALR base setup and the JALR
      if (tgt == jp + 1) begin
        tgt = jp;
      end
      case ($urandom % 7)
        0: imem[i] = enc_r(((f3 == 0 || f3 == 5) && $urandom % 2) ? F7_ALT : F7_BASE,
                           5'($urandom % 8), 5'($urandom % 8), f3, 5'(1 + $urandom % 7));
        1: imem[i] = enc_i(OP_IMM, (f3 == 1 || f3 == 5) ?
                           {(f3 == 5 && $urandom % 2) ? F7_ALT : F7_BASE, 5'($urandom)} :
                           12'($urandom), 5'($urandom % 8), f3, 5'(1 + $urandom % 7));
        2: imem[i] = enc_u($urandom % 2 ? OP_LUI : OP_AUIPC, 21'($urandom),
                           5'(1 + $urandom % 7));
        3: imem[i] = enc_i(OP_LOAD, 12'(4 * k), 5'd0, F3_W, 5'(1 + $urandom % 7));
        4: imem[i] = enc_s(OP_STORE, 13'(4 * k), 5'($urandom % 8), 5'd0, F3_W, 1'b0);
        5: imem[i] = enc_s(OP_BRANCH, 13'(4 * (tgt - i)), 5'($urandom % 8),
                           5'($urandom % 8), br_f3[$urandom % 6], 1'b1);
        default: imem[i] = enc_u(OP_JAL, 21'(4 * (tgt - i)), 5'(1 + $urandom % 7));
      endcase
    end
    // JALR to a forward word address built in x8
    tgt = jp + 2 + $urandom % (n - jp - 1);
    imem[jp] = enc_i(OP_IMM, 12'(4 * tgt), 5'd0, F3_ADD, 5'd8);
    imem[jp + 1] = enc_i(OP_JALR, 12'd0, 5'd8, 3'd0, 5'd9);
  endtask

  // Fault goes on a word the model actually executes
  // mode 1 plants an illegal word, mode 2 a misaligned store
  task automatic plant_fault(input int mode);
    logic [31:0] at;
    at = pc_q[7 + $urandom % (pc_q.size() - 7)];
    if (mode == 1) begin
      imem[at[7:2]] = $urandom % 2 ? enc_i(OP_LOAD, 12'd0, 5'd0, 3'd0, 5'd1) : 32'h0;
    end else begin
      imem[at[7:2]] = enc_s(OP_STORE, 13'(4 * ($urandom % 31) + 2), 5'd1, 5'd0, F3_W, 1'b0);
    end
  endtask

  // ------------------------------
  // Run control
  // ------------------------------
  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < 32; i++) begin
      dmem[i] = fill_word(i);
    end
  endtask

  task automatic run_program(input int mode);
    logic [31:0] hold_pc;
    build_program();
    run_model();
    if (mode == 1 || mode == 2) begin
      plant_fault(mode);
      run_model();
    end
    if (mode == 3) begin
      apply_reset();
      repeat (3 + $urandom % 8) @(negedge clk);
    end
    apply_reset();
    @(negedge clk);
    check_eq("reset ebreak", 32'd0, {31'd0, ebreak});
    check_eq("reset trap", 32'd0, {31'd0, trap});
    check_eq("reset fetch", RESET_PC, imem_raddr);
    foreach (pc_q[i]) begin
      if (i > 0) begin
        @(negedge clk);
      end
      check_eq("fetch address", pc_q[i], imem_raddr);
      check_eq("fetch enable", 32'd1, {31'd0, imem_ren});
      check_eq("load enable", {31'd0, ld_en_q[i]}, {31'd0, dmem_ren});
      if (ld_en_q[i]) begin
        check_eq("load address", ld_addr_q[i], dmem_raddr);
      end
      if (dmem_we) begin
        if (st_addr_q.size() == 0) begin
          $display("store issued that the model does not expect, pc %h", imem_raddr);
          $display("Test FAILED");
          $fatal(1, "unexpected store");
        end
        check_eq("store address", st_addr_q.pop_front(), dmem_waddr);
        check_eq("store data", st_data_q.pop_front(), dmem_wdata);
      end
    end
    check_eq("missing stores", 32'd0, st_addr_q.size());
    // Halt is waited for; the cycle limit catches a core that never stops
    do begin
      @(negedge clk);
    end while (!(ebreak || trap));
    check_eq("ebreak flag", {31'd0, exp_ebreak}, {31'd0, ebreak});
    check_eq("trap flag", {31'd0, exp_trap}, {31'd0, trap});
    hold_pc = imem_raddr;
    repeat (5) begin
      @(negedge clk);
      check_eq("halted fetch", hold_pc, imem_raddr);
      check_eq("halted fetch enable", 32'd0, {31'd0, imem_ren});
      check_eq("halted load", 32'd0, {31'd0, dmem_ren});
      check_eq("halted store", 32'd0, {31'd0, dmem_we});
    end
  endtask

  initial begin
    int modes [NUM_PROGS] = '{0, 0, 1, 2, 0, 3, 1, 2};
    void'($urandom(59));
    clk = 1'b0;
    rst_n = 1'b0;
    cycles = 0;
    for (int i = 0; i < 64; i++) begin
      imem[i] = EBREAK_WORD;
    end
    for (int i = 0; i < 32; i++) begin
      dmem[i] = '0;
    end
    foreach (modes[p]) begin
      run_program(modes[p]);
    end
    $display("Test OK");
    $finish;
  end

endmodule

// File: src.f
hw/rv_isa_pkg.sv
hw/rv_core_pkg.sv
hw/rv_ctrl_if.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_result.sv
hw/rv_core.sv
verif/rv_core_props.sv
verif/rv_core_tb.sv

// File: run.sh
#!/bin/sh
set -e

verilator --binary --timing -f src.f --top-module rv_core_tb -o rv_core_sim

# The simulator exits non-zero on a fatal check, the log decides
./obj_dir/rv_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
  exit 1
fi
grep -q "Test OK" sim.log
